// File: hdl/ep_app_cfg.svh
// Widths, register map, ID constant and transmit buffer sizes
// for the endpoint user application
`ifndef EP_APP_CFG_SVH
`define EP_APP_CFG_SVH

// ---------------------------------------------------------------------------
// Data path widths
// ---------------------------------------------------------------------------
`define EP_REG_ADDR_W    16              // Word address slice
`define EP_REG_DATA_W    32
`define EP_DMA_DATA_W    64              // Pattern word

// ---------------------------------------------------------------------------
// Register map, word addresses
// ---------------------------------------------------------------------------
`define EP_ADDR_CTRL     16'h0000        // Bit 0 is DMA enable
`define EP_ADDR_SCRATCH  16'h0001
`define EP_ADDR_ID       16'h0220        // Read-only board ID
`define EP_ID_VALUE      32'h8888_7777

// Transmit buffer
`define EP_TX_DEPTH      16              // Words, power of two
`define EP_TX_AF_MARGIN  2               // Covers one push in flight

`endif

// File: hdl/ep_reg_pkg.sv
// Register access types: word address, data word and host request
`default_nettype none

`include "ep_app_cfg.svh"

package ep_reg_pkg;

  // Word address, byte offset already stripped
  typedef logic [`EP_REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [`EP_REG_DATA_W-1:0] reg_data_t;

  // One host request as held by the host during req
  typedef struct packed {
    reg_addr_t addr;
    logic      wren;     // Write when set
    reg_data_t wr_data;  // Ignored for reads
  } reg_req_t;

endpackage

`default_nettype wire

// File: hdl/ep_dma_pkg.sv
// DMA types: pattern word and transmit buffer fill level
`default_nettype none

`include "ep_app_cfg.svh"

package ep_dma_pkg;

  // Stream word, also the counter width
  typedef logic [`EP_DMA_DATA_W-1:0] dma_word_t;

  // Fill level, 0 up to full depth inclusive
  typedef logic [$clog2(`EP_TX_DEPTH):0] tx_level_t;

endpackage

`default_nettype wire

// File: hdl/ep_reg_port.sv
// Four-phase req/ack register slave, issues one command per request
`timescale 1ns/1ns
`default_nettype none

module ep_reg_port (
  input  wire logic                 trn_clk_c,
  input  wire logic                 rst_n,
  input  wire logic                 link_up_n,     // High while link is down
  input  wire logic                 req,
  input  wire ep_reg_pkg::reg_req_t reg_req,
  output logic                      ack,
  output ep_reg_pkg::reg_data_t     rd_data,
  output logic                      cmd_valid,
  output ep_reg_pkg::reg_req_t      cmd,
  input  wire logic                 rsp_valid,
  input  wire ep_reg_pkg::reg_data_t rsp_data
);

  typedef enum logic [1:0] {
    ST_IDLE,  // Waiting for req
    ST_BUSY,  // Command issued, waiting on bank
    ST_ACK    // ack held until host drops req
  } state_t;

  state_t state;

  always_ff @(posedge trn_clk_c) begin
    if (!rst_n || link_up_n) begin
      state     <= ST_IDLE;
      ack       <= 1'b0;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;                 // Single-cycle pulse by default
      case (state)
        ST_IDLE: begin
          if (req) begin
            cmd_valid <= 1'b1;
            state     <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (rsp_valid) begin           // Read data or zero on writes
            ack   <= 1'b1;
            state <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (!req) begin                // Host released, close handshake
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge trn_clk_c) begin
    if (state == ST_IDLE && req) cmd <= reg_req;     // Sampled once
    if (state == ST_BUSY && rsp_valid) rd_data <= rsp_data;
  end

endmodule

`default_nettype wire

// File: hdl/ep_reg_bank.sv
// Register bank: control, scratch and ID registers with read-back
`timescale 1ns/1ns
`default_nettype none

`include "ep_app_cfg.svh"

module ep_reg_bank (
  input  wire logic                  trn_clk_c,
  input  wire logic                  rst_n,
  input  wire logic                  link_up_n,
  input  wire logic                  cmd_valid,
  input  wire ep_reg_pkg::reg_req_t  cmd,
  output logic                       rsp_valid,
  output ep_reg_pkg::reg_data_t      rsp_data,
  output logic                       dma_enable
);

  logic                  ctrl_en;   // Control bit 0
  ep_reg_pkg::reg_data_t scratch;
  ep_reg_pkg::reg_data_t rd_mux;

  // ---------------------------------------------------------------------------
  // Write side
  // ---------------------------------------------------------------------------
  always_ff @(posedge trn_clk_c) begin
    if (!rst_n || link_up_n) begin
      ctrl_en <= 1'b0;
      scratch <= '0;
    end else if (cmd_valid && cmd.wren) begin
      case (cmd.addr)
        `EP_ADDR_CTRL:    ctrl_en <= cmd.wr_data[0];
        `EP_ADDR_SCRATCH: scratch <= cmd.wr_data;
        default: ;                       // ID and holes are read-only
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // Read side
  // ---------------------------------------------------------------------------
  always_comb begin
    case (cmd.addr)
      `EP_ADDR_CTRL:    rd_mux = {{(`EP_REG_DATA_W-1){1'b0}}, ctrl_en};
      `EP_ADDR_SCRATCH: rd_mux = scratch;
      `EP_ADDR_ID:      rd_mux = `EP_ID_VALUE;
      default:          rd_mux = '0;     // Unmapped reads as zero
    endcase
  end

  always_ff @(posedge trn_clk_c) begin
    if (!rst_n || link_up_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= cmd_valid;            // One cycle behind the command
    end
  end

  // Writes answer with zero
  always_ff @(posedge trn_clk_c) begin
    if (cmd_valid) rsp_data <= cmd.wren ? '0 : rd_mux;
  end

  assign dma_enable = ctrl_en;

endmodule

`default_nettype wire

// File: hdl/ep_dma_pattern.sv
// DMA test pattern: free-running counter pushed into the transmit buffer
`timescale 1ns/1ns
`default_nettype none

module ep_dma_pattern (
  input  wire logic           trn_clk_c,
  input  wire logic           rst_n,
  input  wire logic           link_up_n,
  input  wire logic           dma_enable,
  input  wire logic           almost_full,
  output logic                push,
  output ep_dma_pkg::dma_word_t push_data
);

  ep_dma_pkg::dma_word_t cnt;  // Next value to send
  logic                  go;

  assign go = dma_enable && !almost_full;

  always_ff @(posedge trn_clk_c) begin
    if (!rst_n || link_up_n) begin
      cnt  <= '0;
      push <= 1'b0;
    end else begin
      push <= go;
      if (go) cnt <= cnt + 1'b1;         // Hold while stalled
    end
  end

  // Counter value before increment, so the stream starts at 0
  always_ff @(posedge trn_clk_c) begin
    if (go) push_data <= cnt;
  end

endmodule

`default_nettype wire

// File: hdl/ep_tx_fifo.sv
// Show-ahead transmit buffer with almost-full flag and link-down clear
`timescale 1ns/1ns
`default_nettype none

`include "ep_app_cfg.svh"

module ep_tx_fifo #(
  parameter int DEPTH = `EP_TX_DEPTH   // Power of two, 4 or more
) (
  input  wire logic                  trn_clk_c,
  input  wire logic                  rst_n,
  input  wire logic                  link_up_n,
  input  wire logic                  push,
  input  wire ep_dma_pkg::dma_word_t push_data,
  output logic                       almost_full,
  output logic                       tx_valid,
  output ep_dma_pkg::dma_word_t      tx_data,
  input  wire logic                  tx_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam ep_dma_pkg::tx_level_t AF_LEVEL =
    ep_dma_pkg::tx_level_t'(DEPTH - `EP_TX_AF_MARGIN);
  localparam ep_dma_pkg::tx_level_t FULL_LEVEL = ep_dma_pkg::tx_level_t'(DEPTH);

  ep_dma_pkg::dma_word_t mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  ep_dma_pkg::tx_level_t level;
  logic                  wr_en;
  logic                  rd_en;

  assign wr_en = push && (level != FULL_LEVEL);  // Drop guard, margin avoids it
  assign rd_en = tx_valid && tx_ready;

  // ---------------------------------------------------------------------------
  // Pointers and level
  // ---------------------------------------------------------------------------
  always_ff @(posedge trn_clk_c) begin
    if (!rst_n || link_up_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;        // Wraps at DEPTH
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;                 // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge trn_clk_c) begin
    if (wr_en) mem[wr_ptr] <= push_data;
  end

  // Head word shown ahead of the read
  assign tx_valid    = (level != '0);
  assign tx_data     = mem[rd_ptr];
  assign almost_full = (level >= AF_LEVEL);

endmodule

`default_nettype wire

// File: hdl/ep_user_app.sv
// Endpoint user application top: register path and DMA pattern stream
`timescale 1ns/1ns
`default_nettype none

module ep_user_app (
  input  wire logic                  trn_clk_c,
  input  wire logic                  rst_n,
  input  wire logic                  link_up_n,
  // Host register port
  input  wire logic                  req,
  input  wire ep_reg_pkg::reg_req_t  reg_req,
  output logic                       ack,
  output ep_reg_pkg::reg_data_t      rd_data,
  // Pattern stream out
  output logic                       tx_valid,
  output ep_dma_pkg::dma_word_t      tx_data,
  input  wire logic                  tx_ready
);

  logic                  cmd_valid;
  ep_reg_pkg::reg_req_t  cmd;
  logic                  rsp_valid;
  ep_reg_pkg::reg_data_t rsp_data;
  logic                  dma_enable;
  logic                  push;
  ep_dma_pkg::dma_word_t push_data;
  logic                  almost_full;   // Back-pressure to generator

  ep_reg_port u_reg_port (
    .trn_clk_c (trn_clk_c),
    .rst_n     (rst_n),
    .link_up_n (link_up_n),
    .req       (req),
    .reg_req   (reg_req),
    .ack       (ack),
    .rd_data   (rd_data),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data)
  );

  ep_reg_bank u_reg_bank (
    .trn_clk_c  (trn_clk_c),
    .rst_n      (rst_n),
    .link_up_n  (link_up_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .dma_enable (dma_enable)
  );

  ep_dma_pattern u_dma_pattern (
    .trn_clk_c   (trn_clk_c),
    .rst_n       (rst_n),
    .link_up_n   (link_up_n),
    .dma_enable  (dma_enable),
    .almost_full (almost_full),
    .push        (push),
    .push_data   (push_data)
  );

  ep_tx_fifo u_tx_fifo (
    .trn_clk_c   (trn_clk_c),
    .rst_n       (rst_n),
    .link_up_n   (link_up_n),
    .push        (push),
    .push_data   (push_data),
    .almost_full (almost_full),
    .tx_valid    (tx_valid),
    .tx_data     (tx_data),
    .tx_ready    (tx_ready)
  );

endmodule

`default_nettype wire

// File: tests/ep_user_app_properties.sv
// Bound assertions on the register handshake and the transmit stream
`timescale 1ns/1ns
`default_nettype none

module ep_user_app_properties (
  input wire logic                  trn_clk_c,
  input wire logic                  rst_n,
  input wire logic                  link_up_n,
  input wire logic                  req,
  input wire logic                  ack,
  input wire logic                  tx_valid,
  input wire ep_dma_pkg::dma_word_t tx_data,
  input wire logic                  tx_ready
);

  int fail_cnt = 0;  // Failed assertion count

  // ack only rises on a held request
  ack_after_req: assert property (@(posedge trn_clk_c) disable iff (!rst_n)
    $rose(ack) |-> req)
    else begin
      fail_cnt++;
      $error("ack rose while req was low");
    end

  // Stalled head word holds
  data_stable: assert property (@(posedge trn_clk_c) disable iff (!rst_n)
    (tx_valid && !tx_ready && !link_up_n) |=> $stable(tx_data))
    else begin
      fail_cnt++;
      $error("tx_data changed while stalled");
    end

  link_clear: assert property (@(posedge trn_clk_c) link_up_n |=> !tx_valid)
    else begin
      fail_cnt++;
      $error("tx_valid high after link down");  // Buffer cleared
    end

endmodule

bind ep_user_app ep_user_app_properties u_props (
  .trn_clk_c (trn_clk_c),
  .rst_n     (rst_n),
  .link_up_n (link_up_n),
  .req       (req),
  .ack       (ack),
  .tx_valid  (tx_valid),
  .tx_data   (tx_data),
  .tx_ready  (tx_ready)
);

`default_nettype wire

// File: tests/tb_ep_user_app.sv
// Testbench for the endpoint user application
// Register map checks, four-phase handshake and pattern stream scoreboard
`timescale 1ns/1ns
`default_nettype none

`include "ep_app_cfg.svh"

module tb_ep_user_app;

  localparam int TIMEOUT = 1000;                 // Cycles allowed per wait

  logic                  trn_clk_c = 1'b0;
  logic                  rst_n;
  logic                  link_up_n;
  logic                  req;
  ep_reg_pkg::reg_req_t  reg_req;
  logic                  ack;
  ep_reg_pkg::reg_data_t rd_data;
  logic                  tx_valid;
  ep_dma_pkg::dma_word_t tx_data;
  logic                  tx_ready = 1'b0;

  logic                  model_ctrl;             // Register model
  ep_reg_pkg::reg_data_t model_scratch;
  ep_dma_pkg::dma_word_t exp_word;               // Next expected stream word
  logic [31:0]           rnd = 32'h781775de;
  int                    n_words = 0;            // Accepted words since start
  int                    reg_errs = 0;
  int                    word_errs = 0;
  int                    proto_errs = 0;
  int                    assert_errs = 0;

  always #20 trn_clk_c = ~trn_clk_c;             // 40 ns period

  ep_user_app u_dut (
    .trn_clk_c (trn_clk_c),
    .rst_n     (rst_n),
    .link_up_n (link_up_n),
    .req       (req),
    .reg_req   (reg_req),
    .ack       (ack),
    .rd_data   (rd_data),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_ready  (tx_ready)
  );

  // ---------------------------------------------------------------------------
  // Reference model and compare tasks
  // ---------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected read data from the register model
  function automatic ep_reg_pkg::reg_data_t exp_read(input ep_reg_pkg::reg_addr_t addr);
    ep_reg_pkg::reg_data_t v;
    v = '0;                                      // Holes read as zero
    if (addr == `EP_ADDR_CTRL) v[0] = model_ctrl;
    else if (addr == `EP_ADDR_SCRATCH) v = model_scratch;
    else if (addr == `EP_ADDR_ID) v = `EP_ID_VALUE;
    return v;
  endfunction

  task automatic check_reg(input string what, input ep_reg_pkg::reg_data_t got,
                           input ep_reg_pkg::reg_data_t exp);
    if (got !== exp) begin
      reg_errs++;
      $display("ERR %0t ns: %s returned %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input ep_dma_pkg::dma_word_t got,
                            input ep_dma_pkg::dma_word_t exp);
    if (got !== exp) begin
      word_errs++;
      $display("ERR %0t ns: stream word %h, expected %h", $time, got, exp);
    end
  endtask

  // Random back-pressure
  always @(posedge trn_clk_c) begin
    rnd = xorshift32(rnd);
    tx_ready <= rnd[0] | rnd[1];                 // Ready about 3 of 4 cycles
  end

  // Stream scoreboard
  always @(posedge trn_clk_c) begin
    if (!rst_n || link_up_n) begin
      exp_word <= '0;                            // Pattern restarts at zero
    end else if (tx_valid && tx_ready) begin
      check_word(tx_data, exp_word);
      exp_word <= exp_word + 1'b1;
      n_words  <= n_words + 1;
    end
  end

  // ---------------------------------------------------------------------------
  // Host side tasks
  // ---------------------------------------------------------------------------
  task automatic reg_access(input ep_reg_pkg::reg_addr_t addr, input logic wren,
                            input ep_reg_pkg::reg_data_t wdata,
                            output ep_reg_pkg::reg_data_t rdata);
    ep_reg_pkg::reg_req_t r;
    int cnt;
    r.addr    = addr;
    r.wren    = wren;
    r.wr_data = wdata;
    rdata     = '0;
    @(posedge trn_clk_c);
    reg_req <= r;
    req     <= 1'b1;
    cnt = 0;
    while (!ack && cnt < TIMEOUT) begin
      @(posedge trn_clk_c);
      cnt++;
    end
    if (!ack) begin
      proto_errs++;
      $display("Timeout: no ack for request to address %h", addr);
      req <= 1'b0;
    end else begin
      rdata = rd_data;                           // Valid together with ack
      req <= 1'b0;
      @(posedge trn_clk_c);
      if (!ack) begin
        proto_errs++;
        $display("ack fell before the host released req at address %h", addr);
      end
      cnt = 0;
      while (ack && cnt < TIMEOUT) begin
        @(posedge trn_clk_c);
        cnt++;
      end
      if (ack) begin
        proto_errs++;
        $display("Timeout: ack stayed high after req was released");
      end
    end
  endtask

  task automatic reg_write(input ep_reg_pkg::reg_addr_t addr,
                           input ep_reg_pkg::reg_data_t data);
    ep_reg_pkg::reg_data_t rdata;
    reg_access(addr, 1'b1, data, rdata);
    check_reg($sformatf("write to %h", addr), rdata, '0);
    if (addr == `EP_ADDR_CTRL) model_ctrl = data[0];
    else if (addr == `EP_ADDR_SCRATCH) model_scratch = data;
  endtask

  task automatic reg_read(input ep_reg_pkg::reg_addr_t addr);
    ep_reg_pkg::reg_data_t rdata;
    reg_access(addr, 1'b0, '0, rdata);
    check_reg($sformatf("read of %h", addr), rdata, exp_read(addr));
  endtask

  task automatic wait_words(input int n);
    int target;
    int cnt;
    target = n_words + n;
    cnt = 0;
    while (n_words < target && cnt < TIMEOUT) begin
      @(posedge trn_clk_c);
      cnt++;
    end
    if (n_words < target) begin
      proto_errs++;
      $display("Timeout: stream stalled, %0d words short", target - n_words);
    end
  endtask

  // Buffer empties and no more words arrive
  task automatic wait_drain();
    int cnt;
    int seen;
    cnt = 0;
    while (tx_valid && cnt < TIMEOUT) begin
      @(posedge trn_clk_c);
      cnt++;
    end
    if (tx_valid) begin
      proto_errs++;
      $display("Timeout: transmit buffer never drained");
    end
    seen = n_words;
    repeat (30) @(posedge trn_clk_c);
    if (n_words != seen) begin
      proto_errs++;
      $display("Stream kept sending words after DMA was disabled");
    end
  endtask

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial begin
    rst_n         <= 1'b0;
    link_up_n     <= 1'b0;
    req           <= 1'b0;
    reg_req       <= '0;
    model_ctrl    = 1'b0;
    model_scratch = '0;
    repeat (5) @(posedge trn_clk_c);
    rst_n <= 1'b1;

    reg_read(`EP_ADDR_ID);                       // ID value and read-only check
    reg_write(`EP_ADDR_ID, 32'h1234_5678);
    reg_read(`EP_ADDR_ID);
    reg_write(`EP_ADDR_SCRATCH, 32'ha5a5_5a5a);
    reg_read(`EP_ADDR_SCRATCH);
    reg_write(`EP_ADDR_SCRATCH, 32'h0bad_f00d);
    reg_read(`EP_ADDR_SCRATCH);
    reg_read(16'h0002);                          // Unmapped holes
    reg_read(16'h0221);
    reg_read(16'hffff);
    reg_read(`EP_ADDR_CTRL);

    reg_write(`EP_ADDR_CTRL, 32'h1);             // Stream under back-pressure
    wait_words(100);
    reg_write(`EP_ADDR_CTRL, 32'h0);
    wait_drain();

    // Link drop in the middle of a running stream
    reg_write(`EP_ADDR_SCRATCH, 32'h5555_aaaa);
    reg_write(`EP_ADDR_CTRL, 32'h1);
    wait_words(10);
    @(posedge trn_clk_c);
    link_up_n <= 1'b1;
    model_ctrl    = 1'b0;
    model_scratch = '0;
    repeat (3) @(posedge trn_clk_c);
    link_up_n <= 1'b0;
    reg_read(`EP_ADDR_CTRL);
    reg_read(`EP_ADDR_SCRATCH);
    reg_write(`EP_ADDR_CTRL, 32'h1);             // Scoreboard expects 0 first
    wait_words(40);
    reg_write(`EP_ADDR_CTRL, 32'h0);
    wait_drain();

    assert_errs = u_dut.u_props.fail_cnt;        // Bound checker failures
    $display("errors: register %0d, stream %0d, protocol %0d, assertion %0d",
             reg_errs, word_errs, proto_errs, assert_errs);
    if (reg_errs + word_errs + proto_errs + assert_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/ep_reg_pkg.sv
hdl/ep_dma_pkg.sv
hdl/ep_reg_port.sv
hdl/ep_reg_bank.sv
hdl/ep_dma_pattern.sv
hdl/ep_tx_fifo.sv
hdl/ep_user_app.sv
tests/ep_user_app_properties.sv
tests/tb_ep_user_app.sv

// File: Bender.yml
package:
  name: ep_user_app

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ep_reg_pkg.sv
      - hdl/ep_dma_pkg.sv
      - hdl/ep_reg_port.sv
      - hdl/ep_reg_bank.sv
      - hdl/ep_dma_pattern.sv
      - hdl/ep_tx_fifo.sv
      - hdl/ep_user_app.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/ep_user_app_properties.sv
      - tests/tb_ep_user_app.sv
